// File: source/dmmu_pkg.sv
// ***************************************************************************
// Data MMU shared definitions
// ***************************************************************************

package dmmu_pkg;

   // Operand and TLB entry width
   localparam int data_width = 32;
   // 8 KB pages
   localparam int page_bits = 13;
   localparam int ppn_bits = data_width - page_bits;

   // SPR group decoded from address bits 15..11
   localparam logic [4:0] spr_group_dmmu = 5'd1;

   // SPR map within the group
   localparam logic [15:0] spr_dmmucr_addr = 16'h0800;
   localparam logic [15:0] spr_dtlb_mr_base = 16'h0A00;
   localparam logic [15:0] spr_dtlb_tr_base = 16'h0A80;
   localparam logic [15:0] spr_dtlb_end = 16'h0B00;

   // Match entry layout, VPN in the top bits
   localparam int match_valid_bit = 0;

   // Translate entry layout, PPN in the top bits
   localparam int tr_ci_bit = 1;
   localparam int tr_ure_bit = 6;
   localparam int tr_uwe_bit = 7;
   localparam int tr_sre_bit = 8;
   localparam int tr_swe_bit = 9;

   // Directory word, points at a second level table
   typedef struct packed {
      logic [ppn_bits-1:0] ppn;
      logic [page_bits-1:0] ignored;
   } pte_dir_t;

   // Second level word, maps one page
   typedef struct packed {
      logic [ppn_bits-1:0] ppn;
      logic [1:0] reserved;
      logic present;
      logic l;
      logic x;
      logic w;
      logic u;
      logic dirty;
      logic accessed;
      logic wom;
      logic wbc;
      logic ci;
      logic cc;
   } pte_leaf_t;

   // Same memory word, decoded by walk level
   typedef union packed {
      pte_dir_t dir;
      pte_leaf_t leaf;
   } pte_t;

endpackage

// File: source/tlb_ram.sv
// ***************************************************************************
// TLB array
// ***************************************************************************

`timescale 1ns/1ps

module tlb_ram #(
   parameter int SET_WIDTH = 6
) (
   input  logic                                clk,
   input  logic [SET_WIDTH-1:0]                addr_i,
   input  logic                                we_i,
   input  logic [dmmu_pkg::data_width-1:0]     din_i,
   output logic [dmmu_pkg::data_width-1:0]     dout_o
);

   // One entry per set
   logic [dmmu_pkg::data_width-1:0] mem [0:(1 << SET_WIDTH)-1];

   // Read before write, old word seen on a write cycle
   always_ff @(posedge clk) begin
      dout_o <= mem[addr_i];
      if (we_i) begin
         mem[addr_i] <= din_i;
      end
   end

endmodule

// File: source/dmmu_spr_port.sv
// ***************************************************************************
// DMMU SPR access
// ***************************************************************************

`timescale 1ns/1ps

module dmmu_spr_port #(
   parameter bit HW_RELOAD = 1'b1
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [15:0]                         spr_addr_i,
   input  logic                                spr_we_i,
   input  logic                                spr_stb_i,
   input  logic [dmmu_pkg::data_width-1:0]     spr_dat_i,
   input  logic [dmmu_pkg::data_width-1:0]     match_dout_i,
   input  logic [dmmu_pkg::data_width-1:0]     trans_dout_i,
   output logic                                match_sel_o,
   output logic                                trans_sel_o,
   output logic [dmmu_pkg::data_width-1:0]     dmmucr_o,
   output logic [dmmu_pkg::data_width-1:0]     spr_dat_o,
   output logic                                spr_ack_o
);

   logic group_hit;
   logic cr_sel;
   logic match_sel_q;
   logic trans_sel_q;
   logic cr_sel_q;
   logic ack_q;

   // Group decode
   assign group_hit = spr_addr_i[15:11] == dmmu_pkg::spr_group_dmmu;

   // Range decode, qualified by strobe
   assign match_sel_o = spr_stb_i &
                        (spr_addr_i >= dmmu_pkg::spr_dtlb_mr_base) &
                        (spr_addr_i < dmmu_pkg::spr_dtlb_tr_base);
   assign trans_sel_o = spr_stb_i &
                        (spr_addr_i >= dmmu_pkg::spr_dtlb_tr_base) &
                        (spr_addr_i < dmmu_pkg::spr_dtlb_end);
   assign cr_sel = spr_stb_i & (spr_addr_i == dmmu_pkg::spr_dmmucr_addr);

   // Selects line up with the registered RAM output
   always_ff @(posedge clk) begin
      if (rst) begin
         match_sel_q <= 1'b0;
         trans_sel_q <= 1'b0;
         cr_sel_q <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         match_sel_q <= match_sel_o;
         trans_sel_q <= trans_sel_o;
         cr_sel_q <= cr_sel;
         ack_q <= spr_stb_i & group_hit;
      end
   end

   // Ack one cycle late, dropped as soon as strobe goes
   assign spr_ack_o = ack_q & spr_stb_i & group_hit;

   // Control register, only with hardware reload
   generate
      if (HW_RELOAD) begin : g_dmmucr
         always_ff @(posedge clk) begin
            if (rst) begin
               dmmucr_o <= '0;
            end else if (cr_sel & spr_we_i) begin
               dmmucr_o <= spr_dat_i;
            end
         end
      end else begin : g_no_dmmucr
         assign dmmucr_o = '0;
      end
   endgenerate

   // Read data, other group addresses give zero
   assign spr_dat_o = match_sel_q ? match_dout_i :
                      trans_sel_q ? trans_dout_i :
                      cr_sel_q    ? dmmucr_o     : '0;

endmodule

// File: source/dmmu_tlb_reload.sv
// ***************************************************************************
// DTLB hardware reload walker
// ***************************************************************************

`timescale 1ns/1ps

module dmmu_tlb_reload #(
   parameter bit HW_RELOAD = 1'b1
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                start_i,
   input  logic [dmmu_pkg::data_width-1:0]     dmmucr_i,
   input  logic [dmmu_pkg::data_width-1:0]     virt_addr_match_i,
   input  logic                                reload_ack_i,
   input  logic [dmmu_pkg::data_width-1:0]     reload_data_i,
   input  logic                                pagefault_clear_i,
   output logic                                reload_req_o,
   output logic [dmmu_pkg::data_width-1:0]     reload_addr_o,
   output logic                                busy_o,
   output logic                                pagefault_o,
   output logic                                match_we_o,
   output logic [dmmu_pkg::data_width-1:0]     match_din_o,
   output logic                                trans_we_o,
   output logic [dmmu_pkg::data_width-1:0]     trans_din_o
);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_get_ptr = 2'd1;
   localparam logic [1:0] st_get_pte = 2'd2;
   localparam logic [1:0] st_read = 2'd3;

   generate
      if (HW_RELOAD) begin : g_walker
         logic [1:0] state;
         logic pagefault_q;
         dmmu_pkg::pte_t pte_word;
         logic [dmmu_pkg::data_width-1:0] trans_entry;
         logic [dmmu_pkg::data_width-1:0] match_entry;

         // Returned word, dir or leaf by state
         assign pte_word = reload_data_i;

         // Busy already in the start cycle
         assign busy_o = (state != st_idle) | start_i;
         assign pagefault_o = pagefault_q & ~pagefault_clear_i;

         // Leaf to translate entry
         always_comb begin
            trans_entry = '0;
            trans_entry[dmmu_pkg::data_width-1:dmmu_pkg::page_bits] = pte_word.leaf.ppn;
            // Write only with W, read always allowed in supervisor
            trans_entry[dmmu_pkg::tr_swe_bit] = pte_word.leaf.w;
            trans_entry[dmmu_pkg::tr_sre_bit] = 1'b1;
            // User needs U
            trans_entry[dmmu_pkg::tr_uwe_bit] = pte_word.leaf.w & pte_word.leaf.u;
            trans_entry[dmmu_pkg::tr_ure_bit] = pte_word.leaf.u;
            // Attribute bits pass through, CI lands on bit 1
            trans_entry[5:0] = {pte_word.leaf.dirty, pte_word.leaf.accessed,
                                pte_word.leaf.wom, pte_word.leaf.wbc,
                                pte_word.leaf.ci, pte_word.leaf.cc};
         end

         // VPN with valid set
         always_comb begin
            match_entry = '0;
            match_entry[dmmu_pkg::data_width-1:dmmu_pkg::page_bits] =
               virt_addr_match_i[dmmu_pkg::data_width-1:dmmu_pkg::page_bits];
            match_entry[dmmu_pkg::match_valid_bit] = 1'b1;
         end

         // Walk control
         always_ff @(posedge clk) begin
            if (rst) begin
               state <= st_idle;
               reload_req_o <= 1'b0;
               pagefault_q <= 1'b0;
               match_we_o <= 1'b0;
               trans_we_o <= 1'b0;
            end else begin
               // Refill writes last one cycle
               match_we_o <= 1'b0;
               trans_we_o <= 1'b0;
               if (pagefault_clear_i) begin
                  pagefault_q <= 1'b0;
               end
               case (state)
                  st_idle: begin
                     reload_req_o <= 1'b0;
                     if (start_i) begin
                        reload_req_o <= 1'b1;
                        state <= st_get_ptr;
                     end
                  end
                  // Directory word, zero pointer faults
                  st_get_ptr: begin
                     if (reload_ack_i) begin
                        if (pte_word.dir.ppn == '0) begin
                           pagefault_q <= 1'b1;
                           reload_req_o <= 1'b0;
                           state <= st_idle;
                        end else begin
                           state <= st_get_pte;
                        end
                     end
                  end
                  // Leaf word, absent page faults
                  st_get_pte: begin
                     if (reload_ack_i) begin
                        reload_req_o <= 1'b0;
                        if (!pte_word.leaf.present) begin
                           pagefault_q <= 1'b1;
                           state <= st_idle;
                        end else begin
                           match_we_o <= 1'b1;
                           trans_we_o <= 1'b1;
                           state <= st_read;
                        end
                     end
                  end
                  // Write cycle, then one cycle for the RAM read
                  st_read: begin
                     if (!trans_we_o) begin
                        state <= st_idle;
                     end
                  end
                  default: begin
                     state <= st_idle;
                  end
               endcase
            end
         end

         // Request address and refill words
         always_ff @(posedge clk) begin
            if (state == st_idle && start_i) begin
               // Directory index from VA bits 31..24
               reload_addr_o <= {dmmucr_i[31:10], virt_addr_match_i[31:24], 2'b00};
            end else if (state == st_get_ptr && reload_ack_i) begin
               // Table index from VA bits 23..13
               reload_addr_o <= {pte_word.dir.ppn, virt_addr_match_i[23:13], 2'b00};
            end
            if (state == st_get_pte && reload_ack_i) begin
               match_din_o <= match_entry;
               trans_din_o <= trans_entry;
            end
         end
      end else begin : g_no_walker
         assign reload_req_o = 1'b0;
         assign reload_addr_o = '0;
         assign busy_o = 1'b0;
         assign pagefault_o = 1'b0;
         assign match_we_o = 1'b0;
         assign match_din_o = '0;
         assign trans_we_o = 1'b0;
         assign trans_din_o = '0;
      end
   endgenerate

endmodule

// File: source/dmmu.sv
// ***************************************************************************
// Data MMU top level
// ***************************************************************************

`timescale 1ns/1ps

module dmmu #(
   parameter int SET_WIDTH = 6,
   parameter bit HW_RELOAD = 1'b1
) (
   input  logic                                clk,
   input  logic                                rst,

   // Lookup
   input  logic                                enable_i,
   input  logic [dmmu_pkg::data_width-1:0]     virt_addr_i,
   input  logic [dmmu_pkg::data_width-1:0]     virt_addr_match_i,
   input  logic                                op_load_i,
   input  logic                                op_store_i,
   input  logic                                supervisor_mode_i,
   output logic [dmmu_pkg::data_width-1:0]     phys_addr_o,
   output logic                                cache_inhibit_o,
   output logic                                tlb_miss_o,
   output logic                                pagefault_o,

   // SPR bus
   input  logic [15:0]                         spr_addr_i,
   input  logic                                spr_we_i,
   input  logic                                spr_stb_i,
   input  logic [dmmu_pkg::data_width-1:0]     spr_dat_i,
   output logic [dmmu_pkg::data_width-1:0]     spr_dat_o,
   output logic                                spr_ack_o,

   // Page table reads
   output logic                                reload_req_o,
   output logic [dmmu_pkg::data_width-1:0]     reload_addr_o,
   output logic                                reload_busy_o,
   input  logic                                reload_ack_i,
   input  logic [dmmu_pkg::data_width-1:0]     reload_data_i,
   output logic                                reload_pagefault_o,
   input  logic                                reload_pagefault_clear_i
);

   localparam int dw = dmmu_pkg::data_width;
   localparam int pb = dmmu_pkg::page_bits;

   logic match_sel;
   logic trans_sel;
   logic [dw-1:0] dmmucr;

   logic [SET_WIDTH-1:0] match_addr;
   logic [SET_WIDTH-1:0] trans_addr;
   logic match_we;
   logic trans_we;
   logic [dw-1:0] match_din;
   logic [dw-1:0] trans_din;
   logic [dw-1:0] match_dout;
   logic [dw-1:0] trans_dout;

   logic reload_match_we;
   logic reload_trans_we;
   logic [dw-1:0] reload_match_din;
   logic [dw-1:0] reload_trans_din;
   logic reload_start;

   // Permission bits of the looked up entry
   logic ure;
   logic uwe;
   logic sre;
   logic swe;

   // SPR access wins the RAM index
   assign match_addr = match_sel ? spr_addr_i[SET_WIDTH-1:0] : virt_addr_i[pb +: SET_WIDTH];
   assign trans_addr = trans_sel ? spr_addr_i[SET_WIDTH-1:0] : virt_addr_i[pb +: SET_WIDTH];

   // Software or refill writes
   assign match_we = (match_sel & spr_we_i) | reload_match_we;
   assign trans_we = (trans_sel & spr_we_i) | reload_trans_we;
   assign match_din = reload_match_we ? reload_match_din : spr_dat_i;
   assign trans_din = reload_trans_we ? reload_trans_din : spr_dat_i;

   tlb_ram #(
      .SET_WIDTH(SET_WIDTH)
   ) match_ram (
      .clk    (clk),
      .addr_i (match_addr),
      .we_i   (match_we),
      .din_i  (match_din),
      .dout_o (match_dout)
   );

   tlb_ram #(
      .SET_WIDTH(SET_WIDTH)
   ) translate_ram (
      .clk    (clk),
      .addr_i (trans_addr),
      .we_i   (trans_we),
      .din_i  (trans_din),
      .dout_o (trans_dout)
   );

   dmmu_spr_port #(
      .HW_RELOAD(HW_RELOAD)
   ) spr_port (
      .clk          (clk),
      .rst          (rst),
      .spr_addr_i   (spr_addr_i),
      .spr_we_i     (spr_we_i),
      .spr_stb_i    (spr_stb_i),
      .spr_dat_i    (spr_dat_i),
      .match_dout_i (match_dout),
      .trans_dout_i (trans_dout),
      .match_sel_o  (match_sel),
      .trans_sel_o  (trans_sel),
      .dmmucr_o     (dmmucr),
      .spr_dat_o    (spr_dat_o),
      .spr_ack_o    (spr_ack_o)
   );

   // Reload on a real access that misses, with a table base set
   assign reload_start = enable_i & tlb_miss_o & (dmmucr[31:10] != '0) &
                         (op_load_i | op_store_i);

   dmmu_tlb_reload #(
      .HW_RELOAD(HW_RELOAD)
   ) reload (
      .clk               (clk),
      .rst               (rst),
      .start_i           (reload_start),
      .dmmucr_i          (dmmucr),
      .virt_addr_match_i (virt_addr_match_i),
      .reload_ack_i      (reload_ack_i),
      .reload_data_i     (reload_data_i),
      .pagefault_clear_i (reload_pagefault_clear_i),
      .reload_req_o      (reload_req_o),
      .reload_addr_o     (reload_addr_o),
      .busy_o            (reload_busy_o),
      .pagefault_o       (reload_pagefault_o),
      .match_we_o        (reload_match_we),
      .match_din_o       (reload_match_din),
      .trans_we_o        (reload_trans_we),
      .trans_din_o       (reload_trans_din)
   );

   assign ure = trans_dout[dmmu_pkg::tr_ure_bit];
   assign uwe = trans_dout[dmmu_pkg::tr_uwe_bit];
   assign sre = trans_dout[dmmu_pkg::tr_sre_bit];
   assign swe = trans_dout[dmmu_pkg::tr_swe_bit];

   // VPN compare against the delayed address, hidden behind a reload fault
   assign tlb_miss_o = ((match_dout[dw-1:pb] != virt_addr_match_i[dw-1:pb]) |
                        ~match_dout[dmmu_pkg::match_valid_bit]) & ~reload_pagefault_o;

   // Mode picks the enable pair, no fault while a walk is running
   assign pagefault_o = (supervisor_mode_i ?
                         ((~swe & op_store_i) | (~sre & op_load_i)) :
                         ((~uwe & op_store_i) | (~ure & op_load_i))) & ~reload_busy_o;

   assign cache_inhibit_o = trans_dout[dmmu_pkg::tr_ci_bit];
   assign phys_addr_o = {trans_dout[dw-1:pb], virt_addr_match_i[pb-1:0]};

endmodule

// File: bench/dmmu_pt_memory.sv
// ***************************************************************************
// Page table memory model
// ***************************************************************************

`timescale 1ns/1ps

module dmmu_pt_memory (
   input  logic        clk,
   input  logic        rst,
   input  logic        req_i,
   input  logic [31:0] addr_i,
   output logic        ack_o,
   output logic [31:0] data_o
);

   // Sparse page table words
   logic [31:0] words [logic [31:0]];
   logic [15:0] lfsr = 16'd42;
   int stall;

   // Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // Two LFSR bits give a 0 to 3 cycle stall
   task automatic pick_stall();
      lfsr = lfsr_step(lfsr);
      stall = lfsr[0];
      lfsr = lfsr_step(lfsr);
      stall = stall * 2 + lfsr[0];
   endtask

   task automatic store(input logic [31:0] addr, input logic [31:0] data);
      words[addr] = data;
   endtask

   initial begin
      ack_o = 1'b0;
      data_o = '0;
      pick_stall();
   end

   // Answer a held request once per ack, outputs move 1 ns after the edge
   always @(posedge clk) begin
      #1;
      if (rst) begin
         ack_o = 1'b0;
      end else if (ack_o) begin
         ack_o = 1'b0;
         pick_stall();
      end else if (req_i) begin
         if (stall == 0) begin
            ack_o = 1'b1;
            // Unmapped words read back as a pattern of the address
            data_o = words.exists(addr_i) ? words[addr_i] : ~addr_i;
         end else begin
            stall = stall - 1;
         end
      end
   end

endmodule

// File: bench/dmmu_tb.sv
// ***************************************************************************
// Data MMU testbench
// ***************************************************************************

`timescale 1ns/1ps

module dmmu_tb;

   // Rough test lengths in cycles, walks at worst stall
   localparam int spr_ops = 200 + 2 * 16 + 40;
   localparam int lookups = 64 + 40;
   localparam int walk_cycles = 2 * (3 + 2) + 6;
   localparam int timeout_ns = 4 * (spr_ops * 4 + lookups * (6 + walk_cycles) + 500);

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic enable_i;
   logic [31:0] virt_addr_i;
   logic [31:0] virt_addr_match_i;
   logic op_load_i;
   logic op_store_i;
   logic supervisor_mode_i;
   logic [31:0] phys_addr_o;
   logic cache_inhibit_o;
   logic tlb_miss_o;
   logic pagefault_o;
   logic [15:0] spr_addr_i;
   logic spr_we_i;
   logic spr_stb_i;
   logic [31:0] spr_dat_i;
   logic [31:0] spr_dat_o;
   logic spr_ack_o;
   logic reload_req_o;
   logic [31:0] reload_addr_o;
   logic reload_busy_o;
   logic reload_ack_i;
   logic [31:0] reload_data_i;
   logic reload_pagefault_o;
   logic reload_pagefault_clear_i;

   // Shadow TLB and page table copy
   logic [31:0] shadow_mr [0:63];
   logic [31:0] shadow_tr [0:63];
   logic [31:0] pt_copy [logic [31:0]];
   logic [31:0] cr_shadow;
   // Table reads the model walk expects, in order
   logic [31:0] exp_addr [$];
   logic fault_pending;
   logic req_seen;
   int errors = 0;

   dmmu #(
      .SET_WIDTH(6),
      .HW_RELOAD(1'b1)
   ) uut (
      .clk                      (clk),
      .rst                      (rst),
      .enable_i                 (enable_i),
      .virt_addr_i              (virt_addr_i),
      .virt_addr_match_i        (virt_addr_match_i),
      .op_load_i                (op_load_i),
      .op_store_i               (op_store_i),
      .supervisor_mode_i        (supervisor_mode_i),
      .phys_addr_o              (phys_addr_o),
      .cache_inhibit_o          (cache_inhibit_o),
      .tlb_miss_o               (tlb_miss_o),
      .pagefault_o              (pagefault_o),
      .spr_addr_i               (spr_addr_i),
      .spr_we_i                 (spr_we_i),
      .spr_stb_i                (spr_stb_i),
      .spr_dat_i                (spr_dat_i),
      .spr_dat_o                (spr_dat_o),
      .spr_ack_o                (spr_ack_o),
      .reload_req_o             (reload_req_o),
      .reload_addr_o            (reload_addr_o),
      .reload_busy_o            (reload_busy_o),
      .reload_ack_i             (reload_ack_i),
      .reload_data_i            (reload_data_i),
      .reload_pagefault_o       (reload_pagefault_o),
      .reload_pagefault_clear_i (reload_pagefault_clear_i)
   );

   dmmu_pt_memory pt (
      .clk    (clk),
      .rst    (rst),
      .req_i  (reload_req_o),
      .addr_i (reload_addr_o),
      .ack_o  (reload_ack_i),
      .data_o (reload_data_i)
   );

   always #2 clk = ~clk;

   // Any walker request at all
   always @(posedge clk) begin
      if (reload_req_o === 1'b1) begin
         req_seen = 1'b1;
      end
   end

   initial begin
      #(timeout_ns);
      $display("Watchdog expired, the run did not complete in time");
      $display("Test FAILED");
      $finish;
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Each acknowledged table read against the next model address
   always @(posedge clk) begin
      if (reload_req_o === 1'b1 && reload_ack_i === 1'b1) begin
         if (exp_addr.size() == 0) begin
            errors++;
            $display("Table read at %h while no walk was expected", reload_addr_o);
         end else begin
            check("reload address", exp_addr.pop_front(), reload_addr_o);
         end
      end
   end

   function automatic logic [31:0] pt_word(input logic [31:0] addr);
      return pt_copy.exists(addr) ? pt_copy[addr] : ~addr;
   endfunction

   task automatic put_pte(input logic [31:0] addr, input logic [31:0] data);
      pt_copy[addr] = data;
      pt.store(addr, data);
   endtask

   // Expected lookup result from one shadow entry pair
   function automatic void predict(input logic [31:0] mr, input logic [31:0] tr,
                                   input logic [31:0] va, input logic sup,
                                   input logic ld, input logic st,
                                   output logic [31:0] pa, output logic miss,
                                   output logic pf, output logic ci);
      pa = {tr[31:13], va[12:0]};
      miss = (mr[31:13] != va[31:13]) || !mr[0];
      ci = tr[1];
      if (sup) begin
         pf = (st && !tr[9]) || (ld && !tr[8]);
      end else begin
         pf = (st && !tr[7]) || (ld && !tr[6]);
      end
   endfunction

   // Two level walk on the table copy, refills the shadow
   task automatic walk_model(input logic [31:0] va);
      dmmu_pkg::pte_t p;
      logic [31:0] tr;
      logic [31:0] addr;
      int idx;
      idx = va[18:13];
      addr = {cr_shadow[31:10], va[31:24], 2'b00};
      exp_addr.push_back(addr);
      p = pt_word(addr);
      if (p.dir.ppn == '0) begin
         fault_pending = 1'b1;
         return;
      end
      addr = {p.dir.ppn, va[23:13], 2'b00};
      exp_addr.push_back(addr);
      p = pt_word(addr);
      if (!p.leaf.present) begin
         fault_pending = 1'b1;
         return;
      end
      tr = '0;
      tr[31:13] = p.leaf.ppn;
      tr[9] = p.leaf.w;
      tr[8] = 1'b1;
      tr[7] = p.leaf.w & p.leaf.u;
      tr[6] = p.leaf.u;
      tr[5:0] = {p.leaf.dirty, p.leaf.accessed, p.leaf.wom, p.leaf.wbc,
                 p.leaf.ci, p.leaf.cc};
      shadow_tr[idx] = tr;
      shadow_mr[idx] = {va[31:13], 12'h000, 1'b1};
   endtask

   // One SPR transfer, held until ack
   task automatic spr_access(input logic [15:0] addr, input logic we,
                             input logic [31:0] data, output logic [31:0] rdata);
      int cycles;
      @(posedge clk);
      #1;
      spr_addr_i = addr;
      spr_we_i = we;
      spr_dat_i = data;
      spr_stb_i = 1'b1;
      #1;
      check("spr ack low with stb", 0, spr_ack_o);
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (!spr_ack_o && cycles < 8);
      check("spr ack latency", 1, cycles);
      rdata = spr_dat_o;
      spr_stb_i = 1'b0;
      spr_we_i = 1'b0;
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      spr_access(addr, 1'b1, data, unused);
      if (addr >= 16'h0A00 && addr < 16'h0A80) begin
         shadow_mr[addr[5:0]] = data;
      end else if (addr >= 16'h0A80 && addr < 16'h0B00) begin
         shadow_tr[addr[5:0]] = data;
      end else if (addr == 16'h0800) begin
         cr_shadow = data;
      end
   endtask

   task automatic spr_expect(input string name, input logic [15:0] addr,
                             input logic [31:0] exp);
      logic [31:0] rdata;
      spr_access(addr, 1'b0, '0, rdata);
      check(name, exp, rdata);
   endtask

   // Address phase, then match phase; waits out a walk if one starts
   task automatic lookup(input string name, input logic [31:0] va, input logic sup,
                         input logic ld, input logic st, output logic saw_busy);
      logic [31:0] exp_pa;
      logic exp_miss;
      logic exp_pf;
      logic exp_ci;
      int idx;
      int waited;
      idx = va[18:13];
      @(posedge clk);
      #1;
      virt_addr_i = va;
      virt_addr_match_i = va;
      supervisor_mode_i = sup;
      @(posedge clk);
      #1;
      enable_i = 1'b1;
      op_load_i = ld;
      op_store_i = st;
      predict(shadow_mr[idx], shadow_tr[idx], va, sup, ld, st,
              exp_pa, exp_miss, exp_pf, exp_ci);
      if (exp_miss && !fault_pending && cr_shadow[31:10] != '0 && (ld || st)) begin
         walk_model(va);
         predict(shadow_mr[idx], shadow_tr[idx], va, sup, ld, st,
                 exp_pa, exp_miss, exp_pf, exp_ci);
      end
      #1;
      saw_busy = reload_busy_o;
      waited = 0;
      while (reload_busy_o && waited < 64) begin
         @(posedge clk);
         #2;
         waited++;
      end
      if (reload_busy_o) begin
         errors++;
         $display("Reload during %s never finished", name);
      end
      check({name, " reload fault"}, fault_pending, reload_pagefault_o);
      if (fault_pending) begin
         check({name, " miss masked"}, 0, tlb_miss_o);
      end else begin
         check({name, " phys"}, exp_pa, phys_addr_o);
         check({name, " miss"}, exp_miss, tlb_miss_o);
         check({name, " pagefault"}, exp_pf, pagefault_o);
         check({name, " ci"}, exp_ci, cache_inhibit_o);
      end
      @(posedge clk);
      #1;
      enable_i = 1'b0;
      op_load_i = 1'b0;
      op_store_i = 1'b0;
   endtask

   task automatic clear_fault();
      @(posedge clk);
      #1;
      reload_pagefault_clear_i = 1'b1;
      @(posedge clk);
      #1;
      reload_pagefault_clear_i = 1'b0;
      fault_pending = 1'b0;
      #1;
      check("fault cleared", 0, reload_pagefault_o);
   endtask

   logic [31:0] va;
   logic [31:0] va_list [0:3];
   logic busy_flag;
   dmmu_pkg::pte_t p;
   dmmu_pkg::pte_t dir_word;

   initial begin
      enable_i = 1'b0;
      virt_addr_i = '0;
      virt_addr_match_i = '0;
      op_load_i = 1'b0;
      op_store_i = 1'b0;
      supervisor_mode_i = 1'b0;
      spr_addr_i = '0;
      spr_we_i = 1'b0;
      spr_stb_i = 1'b0;
      spr_dat_i = '0;
      reload_pagefault_clear_i = 1'b0;
      cr_shadow = '0;
      fault_pending = 1'b0;
      req_seen = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      // Invalidate the whole TLB
      for (int i = 0; i < 64; i++) begin
         spr_write(16'h0A00 + i, '0);
         spr_write(16'h0A80 + i, '0);
      end

      // SPR write and read back
      for (int i = 0; i < 64; i += 13) begin
         spr_write(16'h0A00 + i, 32'h9E37_79B9 * (i + 1));
         spr_write(16'h0A80 + i, 32'h7F4A_7C15 ^ (i << 20));
      end
      for (int i = 0; i < 64; i += 13) begin
         spr_expect("spr match readback", 16'h0A00 + i, shadow_mr[i]);
         spr_expect("spr translate readback", 16'h0A80 + i, shadow_tr[i]);
      end
      spr_write(16'h0800, 32'hFFFF_FC00);
      spr_expect("spr control readback", 16'h0800, 32'hFFFF_FC00);
      spr_write(16'h0800, '0);
      spr_expect("spr control cleared", 16'h0800, '0);
      spr_expect("spr unmapped 0900", 16'h0900, '0);
      spr_expect("spr unmapped 0B10", 16'h0B10, '0);
      for (int i = 0; i < 64; i += 13) begin
         spr_write(16'h0A00 + i, '0);
      end

      // Translation, ci set, then wrong VPN and clear valid
      va = 32'h2468_0000 + (3 << 13) + 32'h5A4;
      spr_write(16'h0A03, {va[31:13], 12'h000, 1'b1});
      spr_write(16'h0A83, {19'h5_5555, 3'b000, 4'b1111, 6'b000010});
      lookup("translate hit", va, 1'b1, 1'b1, 1'b0, busy_flag);
      lookup("translate wrong vpn", va ^ 32'h8000_0000, 1'b0, 1'b1, 1'b0, busy_flag);
      spr_write(16'h0A83, {19'h5_5555, 3'b000, 4'b0101, 6'b000000});
      lookup("translate no ci", va + 32'h10, 1'b0, 1'b0, 1'b1, busy_flag);

      // No walk with a zero table base
      spr_write(16'h0A03, {va[31:13], 12'h000, 1'b0});
      req_seen = 1'b0;
      lookup("invalid entry", va, 1'b1, 1'b1, 1'b0, busy_flag);
      check("no reload busy", 0, busy_flag);
      check("no reload request", 0, req_seen);

      // All enable combinations in both modes
      va = 32'h0AC0_0000 + (5 << 13);
      spr_write(16'h0A05, {va[31:13], 12'h000, 1'b1});
      for (int e = 0; e < 16; e++) begin
         spr_write(16'h0A85, {19'h1_2345, 3'b000, e[3:0], 6'b000000});
         for (int m = 0; m < 4; m++) begin
            lookup("permission", va, m[1], !m[0], m[0], busy_flag);
         end
      end

      // Page table, two walks share directory entry 0x12
      spr_write(16'h0800, 32'h0040_0000);
      va_list[0] = 32'h1234_A123;
      va_list[1] = 32'h1256_0FFC;
      va_list[2] = 32'h3400_E010;
      va_list[3] = 32'hC0DE_6A5A;
      put_pte({22'h1000, 8'h12, 2'b00}, {19'h0_0345, 13'h0});
      put_pte({22'h1000, 8'h34, 2'b00}, {19'h0_1000, 13'h1FFF});
      put_pte({22'h1000, 8'hC0, 2'b00}, {19'h7_FFFF, 13'h0});
      put_pte({22'h1000, 8'h55, 2'b00}, 32'h0000_1FFF);
      for (int i = 0; i < 4; i++) begin
         dir_word = pt_word({cr_shadow[31:10], va_list[i][31:24], 2'b00});
         p.leaf = '0;
         p.leaf.ppn = 19'h1_1111 * (i + 1);
         p.leaf.present = 1'b1;
         p.leaf.w = i[0];
         p.leaf.u = i[1];
         p.leaf.ci = (i == 2);
         p.leaf.dirty = i[0];
         p.leaf.accessed = 1'b1;
         put_pte({dir_word.dir.ppn, va_list[i][23:13], 2'b00}, p);
      end

      // Hardware refill, then SPR readback and a second hit
      for (int i = 0; i < 4; i++) begin
         lookup("reload", va_list[i], i[0], !i[1], i[1], busy_flag);
         check("reload busy seen", 1, busy_flag);
         spr_expect("refilled match", 16'h0A00 + va_list[i][18:13],
                    shadow_mr[va_list[i][18:13]]);
         spr_expect("refilled translate", 16'h0A80 + va_list[i][18:13],
                    shadow_tr[va_list[i][18:13]]);
         lookup("after reload", va_list[i], !i[0], 1'b1, 1'b0, busy_flag);
         check("hit without reload", 0, busy_flag);
      end

      // Zero pointer fault, sticky until cleared
      lookup("zero pointer", 32'h5500_2000, 1'b1, 1'b1, 1'b0, busy_flag);
      check("zero pointer fault", 1, reload_pagefault_o);
      repeat (3) @(posedge clk);
      #1;
      check("fault sticky", 1, reload_pagefault_o);
      clear_fault();

      // Absent leaf under an existing directory entry
      put_pte({19'h0_1000, 11'h00A, 2'b00}, 32'h0000_0000);
      lookup("absent leaf", 32'h3401_4000, 1'b0, 1'b0, 1'b1, busy_flag);
      check("absent leaf fault", 1, reload_pagefault_o);
      clear_fault();
      check("table reads outstanding", 0, exp_addr.size());

      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: project.f
source/dmmu_pkg.sv
source/tlb_ram.sv
source/dmmu_spr_port.sv
source/dmmu_tlb_reload.sv
source/dmmu.sv
bench/dmmu_pt_memory.sv
bench/dmmu_tb.sv

// File: Bender.yml
package:
  name: dmmu

sources:
  - source/dmmu_pkg.sv
  - source/tlb_ram.sv
  - source/dmmu_spr_port.sv
  - source/dmmu_tlb_reload.sv
  - source/dmmu.sv
  - target: test
    files:
      - bench/dmmu_pt_memory.sv
      - bench/dmmu_tb.sv
